/* include/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Serial timing
`define UART_CLKS_PER_BIT 16 // Clock cycles per serial bit

// Host-side buffering
`define UART_FIFO_DEPTH 16 // Entries in each byte queue

`endif

/* hw/uart_pkg.sv */
package uart_pkg;

    typedef logic [7:0]  byte_t;     // One data byte
    typedef logic [15:0] baud_cnt_t; // Cycle count within a bit period
    typedef logic [3:0]  bit_idx_t;  // Bit position within a frame

    typedef struct packed {
        logic tx_full;        // Transmit queue cannot take a write
        logic rx_empty;       // Nothing to read
        logic rx_frame_error; // Bad stop bit, one-cycle strobe
        logic rx_overrun;     // Received byte dropped, one-cycle strobe
    } uart_status_t;

    typedef enum logic [1:0] {
        TX_IDLE,  // Line high, waiting for a byte
        TX_START, // Driving the start bit
        TX_DATA,  // Eight data bits LSB first
        TX_STOP   // Driving the stop bit
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,  // Waiting for a falling edge
        RX_START, // Qualifying the start bit
        RX_DATA,  // Sampling data bits
        RX_STOP   // Judging the stop bit
    } rx_state_t;

endpackage

/* hw/byte_fifo.sv */
module byte_fifo #(
    parameter int DEPTH = 8 // Entries, two or more
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,      // Write strobe
    input  uart_pkg::byte_t push_data,
    input  logic            pop,       // Head consumed
    output uart_pkg::byte_t head_data, // Show-ahead head byte
    output logic            empty,
    output logic            full,
    output logic            overflow   // Push dropped this cycle
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uart_pkg::byte_t  mem [DEPTH]; // Circular storage
    logic [PTR_W-1:0] wr_ptr;      // Next free slot
    logic [PTR_W-1:0] rd_ptr;      // Current head
    logic [CNT_W-1:0] count;       // Occupancy
    logic             do_push;
    logic             do_pop;

    // Pointer advance with wrap at DEPTH, any depth allowed
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign do_push   = push && !full;  // Write accepted
    assign do_pop    = pop && !empty;  // Pop on empty ignored
    assign overflow  = push && full;   // Byte lost
    assign head_data = mem[rd_ptr];    // Combinational read

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* hw/uart_tx.sv */
`include "uart_params.svh"

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::byte_t fifo_data,  // Head of transmit queue
    input  logic            fifo_empty,
    output logic            pop,        // Head byte taken this cycle
    output logic            tx_line     // Serial out, idle high
);

    localparam uart_pkg::baud_cnt_t LAST_CNT =
        uart_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
    localparam uart_pkg::bit_idx_t LAST_BIT = uart_pkg::bit_idx_t'(7);

    uart_pkg::tx_state_t state;
    uart_pkg::baud_cnt_t baud_cnt;  // Cycles into current bit
    uart_pkg::bit_idx_t  bit_idx;   // Data bit being sent
    uart_pkg::byte_t     shift_reg; // Remaining data bits
    logic                bit_done;  // Last cycle of a bit period
    logic                shifting;

    assign bit_done = (baud_cnt == LAST_CNT);
    assign shifting = bit_done &&
                      ((state == uart_pkg::TX_START) || (state == uart_pkg::TX_DATA));

    // Take the next byte when idle, or straight at the end of a stop bit
    assign pop = !fifo_empty &&
                 ((state == uart_pkg::TX_IDLE) ||
                  ((state == uart_pkg::TX_STOP) && bit_done));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= uart_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx_line  <= 1'b1;
        end else begin
            if ((state == uart_pkg::TX_IDLE) || bit_done) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end

            case (state)
                uart_pkg::TX_IDLE: begin
                    if (pop) begin
                        state   <= uart_pkg::TX_START;
                        tx_line <= 1'b0; // Start bit
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_done) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                        tx_line <= shift_reg[0]; // LSB first
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == LAST_BIT) begin
                            state   <= uart_pkg::TX_STOP;
                            tx_line <= 1'b1; // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_line <= shift_reg[0];
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_done) begin
                        if (pop) begin
                            state   <= uart_pkg::TX_START; // Back-to-back frame
                            tx_line <= 1'b0;
                        end else begin
                            state <= uart_pkg::TX_IDLE;
                        end
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg <= fifo_data;
        end else if (shifting) begin
            shift_reg <= shift_reg >> 1; // Next bit into position 0
        end
    end

endmodule

/* hw/uart_rx.sv */
`include "uart_params.svh"

module uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx_line,       // Asynchronous serial in
    output uart_pkg::byte_t rx_byte,       // Last assembled byte
    output logic            rx_byte_valid, // Good frame strobe
    output logic            frame_error    // Low stop bit strobe
);

    localparam uart_pkg::baud_cnt_t LAST_CNT =
        uart_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
    localparam uart_pkg::baud_cnt_t MID_CNT =
        uart_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam uart_pkg::bit_idx_t LAST_BIT = uart_pkg::bit_idx_t'(7);

    logic                sync_q1;   // First synchronizer stage
    logic                line_s;    // Synchronized line
    uart_pkg::rx_state_t state;
    uart_pkg::baud_cnt_t baud_cnt;  // Cycles since last sample point
    uart_pkg::bit_idx_t  bit_idx;   // Data bit being sampled
    uart_pkg::byte_t     shift_reg; // Byte under assembly
    logic                wait_high; // Bad stop seen, line still low
    logic                sample;    // Mid-point of a data or stop bit

    assign sample  = (baud_cnt == LAST_CNT);
    assign rx_byte = shift_reg;

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q1 <= 1'b1;
            line_s  <= 1'b1;
        end else begin
            sync_q1 <= rx_line;
            line_s  <= sync_q1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= uart_pkg::RX_IDLE;
            baud_cnt      <= '0;
            bit_idx       <= '0;
            wait_high     <= 1'b0;
            rx_byte_valid <= 1'b0;
            frame_error   <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0; // Strobes by default low
            frame_error   <= 1'b0;
            baud_cnt      <= baud_cnt + 1'b1;

            case (state)
                uart_pkg::RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!line_s) begin
                        state <= uart_pkg::RX_START; // Possible start edge
                    end
                end
                uart_pkg::RX_START: begin
                    if (baud_cnt == MID_CNT) begin
                        baud_cnt <= '0; // Count from start bit middle
                        bit_idx  <= '0;
                        if (line_s) begin
                            state <= uart_pkg::RX_IDLE; // Glitch
                        end else begin
                            state <= uart_pkg::RX_DATA;
                        end
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (sample) begin
                        baud_cnt <= '0;
                        if (bit_idx == LAST_BIT) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (wait_high) begin
                        baud_cnt <= '0;
                        if (line_s) begin
                            wait_high <= 1'b0;
                            state     <= uart_pkg::RX_IDLE;
                        end
                    end else if (sample) begin
                        baud_cnt <= '0;
                        if (line_s) begin
                            rx_byte_valid <= 1'b1;
                            state         <= uart_pkg::RX_IDLE;
                        end else begin
                            frame_error <= 1'b1; // Byte dropped
                            wait_high   <= 1'b1;
                        end
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // Byte assembly LSB first
    always_ff @(posedge clk) begin
        if ((state == uart_pkg::RX_DATA) && sample) begin
            shift_reg <= {line_s, shift_reg[7:1]};
        end
    end

endmodule

/* hw/uart_top.sv */
`include "uart_params.svh"

module uart_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tx_write, // One-cycle host write strobe
    input  uart_pkg::byte_t        tx_data,
    input  logic                   rx_read,  // One-cycle host read strobe
    input  logic                   rx_line,  // Serial in
    output logic                   tx_line,  // Serial out
    output uart_pkg::byte_t        rx_data,  // Head of receive queue
    output uart_pkg::uart_status_t status
);

    uart_pkg::byte_t tx_head;        // Next byte to send
    logic            tx_empty;
    logic            tx_full;
    logic            tx_pop;
    uart_pkg::byte_t rx_byte;        // Byte from deserializer
    logic            rx_byte_valid;
    logic            rx_frame_error;
    logic            rx_empty;
    logic            rx_overrun;     // Receive queue dropped a byte

    byte_fifo #(
        .DEPTH(`UART_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (tx_write),
        .push_data(tx_data),
        .pop      (tx_pop),
        .head_data(tx_head),
        .empty    (tx_empty),
        .full     (tx_full),
        .overflow () // Host watches tx_full instead
    );

    uart_tx u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .fifo_data (tx_head),
        .fifo_empty(tx_empty),
        .pop       (tx_pop),
        .tx_line   (tx_line)
    );

    uart_rx u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_line      (rx_line),
        .rx_byte      (rx_byte),
        .rx_byte_valid(rx_byte_valid),
        .frame_error  (rx_frame_error)
    );

    byte_fifo #(
        .DEPTH(`UART_FIFO_DEPTH)
    ) u_rx_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (rx_byte_valid),
        .push_data(rx_byte),
        .pop      (rx_read),
        .head_data(rx_data),
        .empty    (rx_empty),
        .full     (),        // Overflow strobe reports the loss
        .overflow (rx_overrun)
    );

    // Host status word
    assign status.tx_full        = tx_full;
    assign status.rx_empty       = rx_empty;
    assign status.rx_frame_error = rx_frame_error;
    assign status.rx_overrun     = rx_overrun;

endmodule

/* bench/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // Reset low for the first 16 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

/* bench/uart_assertions.sv */
module uart_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   tx_line,
    input logic                   tx_write, // Host write strobe
    input logic                   rx_read,  // Host read strobe
    input uart_pkg::tx_state_t    tx_state, // Serializer FSM state
    input uart_pkg::uart_status_t status
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0; // Assertion failures so far

    // Idle serializer keeps the line at mark level
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_state == uart_pkg::TX_IDLE) |-> tx_line)
        else begin
            failures++;
            $error("tx_line low while the serializer is idle");
        end

    frame_error_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        status.rx_frame_error |=> !status.rx_frame_error)
        else begin
            failures++;
            $error("rx_frame_error held longer than one cycle");
        end

    overrun_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        status.rx_overrun |=> !status.rx_overrun)
        else begin
            failures++;
            $error("rx_overrun held longer than one cycle");
        end

    // Transmit queue fills only through a host write
    tx_full_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(status.tx_full) |-> $past(tx_write))
        else begin
            failures++;
            $error("tx_full rose without a host write");
        end

    // Receive queue drains only through a host read
    rx_empty_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(status.rx_empty) |-> $past(rx_read))
        else begin
            failures++;
            $error("rx_empty rose without a host read");
        end

endmodule

bind uart_top uart_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_line (tx_line),
    .tx_write(tx_write),
    .rx_read (rx_read),
    .tx_state(u_tx.state),
    .status  (status)
);

/* bench/uart_tb.sv */
`include "uart_params.svh"

module uart_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CYCLES = `UART_CLKS_PER_BIT;
    localparam int DEPTH      = `UART_FIFO_DEPTH;
    localparam int WAIT_LIMIT = 40 * BIT_CYCLES; // Four frame times

    logic                   clk;
    logic                   rst_n;
    logic                   tx_write;
    logic                   rx_read;
    logic                   tx_line;
    logic                   rx_line;
    logic                   loopback;      // rx_line follows tx_line
    logic                   drv_line;      // Bench line in override mode
    uart_pkg::byte_t        tx_data;
    uart_pkg::byte_t        rx_data;
    uart_pkg::uart_status_t status;
    uart_pkg::byte_t        rx_model_q[$]; // Expected receive queue contents
    uart_pkg::byte_t        tx_sent_q[$];  // Bytes still due on tx_line
    int                     mismatch_count;
    int                     other_count;
    int                     frame_errors;  // rx_frame_error pulses seen
    int                     overruns;      // rx_overrun pulses seen
    int                     expected_drops;

    assign rx_line = loopback ? tx_line : drv_line;

    tb_clock u_clock (
        .clk  (clk),
        .rst_n(rst_n)
    );

    uart_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_write(tx_write),
        .tx_data (tx_data),
        .rx_read (rx_read),
        .rx_line (rx_line),
        .tx_line (tx_line),
        .rx_data (rx_data),
        .status  (status)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("MISMATCH %s: got %0h expected %0h", name, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        other_count++;
    endtask

    // Keeps the drive point 1 ns after each edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_frame(input uart_pkg::byte_t data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0}; // Start bit goes out first
        for (int i = 0; i < 10; i++) begin
            drv_line = bits[i];
            idle_cycles(BIT_CYCLES);
        end
        drv_line = 1'b1;
    endtask

    // Model keeps what a full receive queue would keep
    task automatic send_good_frame(input uart_pkg::byte_t data);
        if (rx_model_q.size() < DEPTH) begin
            rx_model_q.push_back(data);
        end else begin
            expected_drops++;
        end
        send_frame(data, 1'b1);
    endtask

    task automatic check_idle_state();
        check_value("tx_line", tx_line, 1);
        check_value("status.rx_empty", status.rx_empty, 1);
        check_value("status.tx_full", status.tx_full, 0);
        check_value("status.rx_frame_error", status.rx_frame_error, 0);
        check_value("status.rx_overrun", status.rx_overrun, 0);
    endtask

    task automatic write_random(input int n);
        uart_pkg::byte_t data;
        int              cycles;
        for (int i = 0; i < n; i++) begin
            cycles = 0;
            while (status.tx_full && cycles < WAIT_LIMIT) begin
                idle_cycles(1);
                cycles++;
            end
            assert (!status.tx_full)
                else report_failure("Timeout: transmit queue stayed full");
            if (!status.tx_full) begin
                data     = uart_pkg::byte_t'($urandom);
                tx_data  = data;
                tx_write = 1'b1;
                rx_model_q.push_back(data);
                tx_sent_q.push_back(data);
                idle_cycles(1);
                tx_write = 1'b0;
            end
            idle_cycles($urandom_range(2, 0)); // Uneven write spacing
        end
    endtask

    // Pops each byte as soon as it shows up
    task automatic read_expected(input int n, input int limit);
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        while (got < n && cycles < limit) begin
            rx_read = 1'b0;
            if (!status.rx_empty) begin
                assert (rx_model_q.size() != 0)
                    else report_failure("Receive queue holds a byte that was never sent");
                if (rx_model_q.size() != 0) begin
                    check_value("rx_data", rx_data, rx_model_q.pop_front());
                end
                rx_read = 1'b1;
                got++;
            end
            idle_cycles(1);
            cycles++;
        end
        rx_read = 1'b0;
        assert (got == n) else report_failure("Timeout: receive queue came up short");
    endtask

    always @(negedge clk) begin
        if (rst_n && status.rx_frame_error) begin
            frame_errors++;
        end
        if (rst_n && status.rx_overrun) begin
            overruns++;
        end
    end

    // Independent 8N1 decoder on tx_line
    initial begin : frame_decoder
        uart_pkg::byte_t data;
        logic            prev_line;
        prev_line = 1'b1;
        forever begin
            @(negedge clk);
            if (rst_n && prev_line && !tx_line) begin
                repeat (BIT_CYCLES / 2 - 1) @(negedge clk); // Middle of start bit
                check_value("tx_line start bit", tx_line, 0);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    data[i] = tx_line; // LSB first
                end
                repeat (BIT_CYCLES) @(negedge clk);
                check_value("tx_line stop bit", tx_line, 1);
                assert (tx_sent_q.size() != 0)
                    else report_failure("Frame on tx_line without a written byte");
                if (tx_sent_q.size() != 0) begin
                    check_value("tx_line data", data, tx_sent_q.pop_front());
                end
            end
            prev_line = tx_line;
        end
    end

    initial begin : main
        int base_errors;
        int base_overruns;
        int base_drops;
        int assert_failures;
        tx_write = 1'b0;
        tx_data  = '0;
        rx_read  = 1'b0;
        loopback = 1'b0;
        drv_line = 1'b1;
        void'($urandom(32'hcea5));

        // Outputs idle from the first reset edge on
        @(posedge clk);
        for (int i = 0; i < 40 && !rst_n; i++) begin
            @(negedge clk);
            check_idle_state();
        end
        assert (rst_n) else report_failure("Reset was never released");
        repeat (3) begin
            @(negedge clk);
            check_idle_state();
        end
        @(posedge clk);
        #1;

        loopback = 1'b1;
        fork
            write_random(40);
            read_expected(40, 60 * 10 * BIT_CYCLES);
        join
        idle_cycles(BIT_CYCLES);
        assert (tx_sent_q.size() == 0)
            else report_failure("Written bytes never appeared on tx_line");

        loopback = 1'b0; // Override mode with the line idle high
        idle_cycles(BIT_CYCLES);
        base_errors = frame_errors;
        send_frame(8'h5a, 1'b0); // Low stop bit
        idle_cycles(2 * BIT_CYCLES);
        check_value("rx_frame_error pulses", frame_errors - base_errors, 1);
        check_value("status.rx_empty", status.rx_empty, 1);
        send_good_frame(uart_pkg::byte_t'($urandom));
        read_expected(1, WAIT_LIMIT);

        base_errors = frame_errors;
        drv_line    = 1'b0;
        idle_cycles(BIT_CYCLES / 4); // Well under half a bit
        drv_line    = 1'b1;
        idle_cycles(12 * BIT_CYCLES);
        check_value("rx_frame_error pulses", frame_errors - base_errors, 0);
        check_value("status.rx_empty", status.rx_empty, 1);

        base_overruns = overruns;
        base_drops    = expected_drops;
        repeat (DEPTH + 4) begin
            send_good_frame(uart_pkg::byte_t'($urandom));
        end
        idle_cycles(BIT_CYCLES);
        check_value("rx_overrun pulses", overruns - base_overruns, expected_drops - base_drops);
        read_expected(DEPTH, WAIT_LIMIT);
        check_value("status.rx_empty", status.rx_empty, 1);

        assert_failures = u_dut.u_assertions.failures;
        $display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, other_count, assert_failures);
        if (mismatch_count == 0 && other_count == 0 && assert_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* uart_fifo.f */
+incdir+include
hw/uart_pkg.sv
hw/byte_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
bench/tb_clock.sv
bench/uart_assertions.sv
bench/uart_tb.sv

/* Bender.yml */
package:
  name: uart_fifo

export_include_dirs:
  - include

sources:
  - hw/uart_pkg.sv
  - hw/byte_fifo.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/uart_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/uart_assertions.sv
      - bench/uart_tb.sv
